/* bu_rs_cfg_pkg.sv */
// Data widths and default sizing shared by every block of the branch reservation station
package bu_rs_cfg_pkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------
    localparam int unsigned XLEN        = 32;   // Register and PC width
    localparam int unsigned ROB_IDX_LEN = 4;    // Reorder buffer tag width
    localparam int unsigned B_IMM       = 12;   // Branch immediate width

    // ------------------------------
    // Station sizing
    // ------------------------------
    // Number of entries, must stay a power of two so the pointers wrap for free
    localparam int unsigned RS_DEPTH_DEFAULT = 4;

endpackage

/* bu_rs_types_pkg.sv */
// Branch encodings and the entry and CDB record layouts used across the reservation station
package bu_rs_types_pkg;

    // Branch kinds understood by the branch unit
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5
    } branch_type_e;

    // Word broadcast on the common data bus
    typedef struct packed {
        logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0] rob_idx;       // Producer tag
        logic [bu_rs_cfg_pkg::XLEN-1:0]        value;         // Produced value
        logic                                  except_raised; // Producer faulted, value unusable
    } cdb_data_t;

    // Payload of one station entry, status flags live outside
    typedef struct packed {
        branch_type_e                          branch_type;
        logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0] rs1_idx;      // Tag awaited for rs1
        logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0] rs2_idx;      // Tag awaited for rs2
        logic [bu_rs_cfg_pkg::XLEN-1:0]        rs1_value;
        logic [bu_rs_cfg_pkg::XLEN-1:0]        rs2_value;
        logic [bu_rs_cfg_pkg::B_IMM-1:0]       imm_value;
        logic [bu_rs_cfg_pkg::XLEN-1:0]        pred_pc;      // PC of the branch itself
        logic [bu_rs_cfg_pkg::XLEN-1:0]        pred_target;  // Target guessed by fetch
        logic                                  pred_taken;   // Direction guessed by fetch
        logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0] res_idx;      // ROB slot for the result
        logic                                  mispredicted; // Outcome from the branch unit
    } rs_entry_t;

endpackage

/* rs_ctrl_if.sv */
// Strobes, pointers and status between the station controller and its entry array
interface rs_ctrl_if #(
    parameter int unsigned RS_DEPTH = bu_rs_cfg_pkg::RS_DEPTH_DEFAULT
);

    localparam int unsigned IDX_W = $clog2(RS_DEPTH);

    // Operation strobes
    logic             push;       // Write new branch at tail
    logic             ex;         // Entry at ex_idx handed to the branch unit
    logic             wr_res;     // Branch unit result lands at wr_res_idx
    logic             pop;        // Head result taken by the CDB

    // Pointers
    logic [IDX_W-1:0] tail_idx;
    logic [IDX_W-1:0] ex_idx;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] wr_res_idx;

    // Status of the entries named by the pointers
    logic             tail_free;  // Tail slot empty
    logic             ex_ready;   // Dispatch slot has both operands and waits
    logic             res_ready;  // Head slot holds its outcome
    logic             wr_busy;    // Write-back slot is executing

    modport ctrl (
        output push, ex, wr_res, pop,
        output tail_idx, ex_idx, head_idx, wr_res_idx,
        input  tail_free, ex_ready, res_ready, wr_busy
    );

    modport array (
        input  push, ex, wr_res, pop,
        input  tail_idx, ex_idx, head_idx, wr_res_idx,
        output tail_free, ex_ready, res_ready, wr_busy
    );

endinterface

/* bu_rs_entry.sv */
// One reservation station slot holding a branch, its operand snooping and its status flags
module bu_rs_entry (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  bu_rs_types_pkg::rs_entry_t entry_i,
    input  logic                       rs1_ready_i,
    input  logic                       rs2_ready_i,
    input  logic                       ex_i,
    input  logic                       wr_res_i,
    input  logic                       mispredict_i,
    input  logic                       pop_i,
    input  logic                       cdb_valid_i,
    input  bu_rs_types_pkg::cdb_data_t cdb_data_i,
    output bu_rs_types_pkg::rs_entry_t entry_o,
    output logic                       valid_o,
    output logic                       busy_o,
    output logic                       ex_ready_o,
    output logic                       res_ready_o
);

    bu_rs_types_pkg::rs_entry_t entry_q;
    logic valid_q, busy_q, rs1_rdy_q, rs2_rdy_q, res_rdy_q;
    logic cdb_ok, cap_rs1, cap_rs2;

    // ------------------------------
    // Operand snooping
    // ------------------------------
    // Faulted producers never release their consumers
    assign cdb_ok  = cdb_valid_i & ~cdb_data_i.except_raised;
    assign cap_rs1 = valid_q & ~rs1_rdy_q & cdb_ok & (cdb_data_i.rob_idx == entry_q.rs1_idx);
    assign cap_rs2 = valid_q & ~rs2_rdy_q & cdb_ok & (cdb_data_i.rob_idx == entry_q.rs2_idx);

    // Payload
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entry_q <= entry_i;
        end else begin
            if (cap_rs1) begin
                entry_q.rs1_value <= cdb_data_i.value;
            end
            if (cap_rs2) begin
                entry_q.rs2_value <= cdb_data_i.value;
            end
            if (wr_res_i) begin
                entry_q.mispredicted <= mispredict_i;  // Outcome from the branch unit
            end
        end
    end

    // ------------------------------
    // Status flags
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            busy_q    <= 1'b0;
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
            res_rdy_q <= 1'b0;
        end else if (flush_i) begin
            valid_q   <= 1'b0;
            busy_q    <= 1'b0;
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
            res_rdy_q <= 1'b0;
        end else if (push_i) begin
            valid_q   <= 1'b1;
            busy_q    <= 1'b0;
            rs1_rdy_q <= rs1_ready_i;
            rs2_rdy_q <= rs2_ready_i;
            res_rdy_q <= 1'b0;
        end else begin
            if (cap_rs1) begin
                rs1_rdy_q <= 1'b1;
            end
            if (cap_rs2) begin
                rs2_rdy_q <= 1'b1;
            end
            if (ex_i) begin
                busy_q <= 1'b1;     // In flight in the branch unit
            end
            if (wr_res_i) begin
                busy_q    <= 1'b0;  // Only busy drops, operands and payload stay
                res_rdy_q <= 1'b1;
            end
            if (pop_i) begin
                valid_q <= 1'b0;    // Slot free for the next push
            end
        end
    end

    assign entry_o     = entry_q;
    assign valid_o     = valid_q;
    assign busy_o      = busy_q;
    // A finished branch is never offered to the branch unit again
    assign ex_ready_o  = valid_q & ~busy_q & ~res_rdy_q & rs1_rdy_q & rs2_rdy_q;
    assign res_ready_o = valid_q & res_rdy_q;

endmodule

/* bu_rs_slot_array.sv */
// Entry storage of the branch reservation station, steered by the controller strobes
module bu_rs_slot_array #(
    parameter int unsigned RS_DEPTH = bu_rs_cfg_pkg::RS_DEPTH_DEFAULT
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,
    rs_ctrl_if.array                               arr_if,
    // Push fields
    input  bu_rs_types_pkg::branch_type_e          branch_type_i,
    input  logic                                   rs1_ready_i,
    input  logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  rs1_idx_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         rs1_value_i,
    input  logic                                   rs2_ready_i,
    input  logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  rs2_idx_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         rs2_value_i,
    input  logic [bu_rs_cfg_pkg::B_IMM-1:0]        imm_value_i,
    input  logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  dest_idx_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         pred_pc_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         pred_target_i,
    input  logic                                   pred_taken_i,
    // Snooped CDB and branch unit result
    input  logic                                   cdb_valid_i,
    input  bu_rs_types_pkg::cdb_data_t             cdb_data_i,
    input  logic                                   mispredict_i,
    // Toward the branch unit
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_rs1_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_rs2_o,
    output logic [bu_rs_cfg_pkg::B_IMM-1:0]        bu_imm_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_pred_pc_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_pred_target_o,
    output logic                                   bu_pred_taken_o,
    output bu_rs_types_pkg::branch_type_e          bu_branch_type_o,
    // Toward the CDB
    output logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  cdb_rob_idx_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         cdb_value_o
);

    import bu_rs_cfg_pkg::*;
    import bu_rs_types_pkg::*;

    localparam int unsigned IDX_W = $clog2(RS_DEPTH);

    rs_entry_t            new_entry;
    rs_entry_t            entries_a [RS_DEPTH];
    rs_entry_t            ex_entry, head_entry;
    logic [RS_DEPTH-1:0]  valid_a, busy_a, ex_ready_a, res_ready_a;

    // Incoming branch, outcome filled in later
    always_comb begin
        new_entry.branch_type  = branch_type_i;
        new_entry.rs1_idx      = rs1_idx_i;
        new_entry.rs2_idx      = rs2_idx_i;
        new_entry.rs1_value    = rs1_value_i;
        new_entry.rs2_value    = rs2_value_i;
        new_entry.imm_value    = imm_value_i;
        new_entry.pred_pc      = pred_pc_i;
        new_entry.pred_target  = pred_target_i;
        new_entry.pred_taken   = pred_taken_i;
        new_entry.res_idx      = dest_idx_i;
        new_entry.mispredicted = 1'b0;
    end

    // ------------------------------
    // Entries
    // ------------------------------
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        bu_rs_entry u_entry (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .flush_i      (flush_i),
            .push_i       (arr_if.push   && (arr_if.tail_idx   == IDX_W'(i))),
            .entry_i      (new_entry),
            .rs1_ready_i  (rs1_ready_i),
            .rs2_ready_i  (rs2_ready_i),
            .ex_i         (arr_if.ex     && (arr_if.ex_idx     == IDX_W'(i))),
            .wr_res_i     (arr_if.wr_res && (arr_if.wr_res_idx == IDX_W'(i))),
            .mispredict_i (mispredict_i),
            .pop_i        (arr_if.pop    && (arr_if.head_idx   == IDX_W'(i))),
            .cdb_valid_i  (cdb_valid_i),
            .cdb_data_i   (cdb_data_i),
            .entry_o      (entries_a[i]),
            .valid_o      (valid_a[i]),
            .busy_o       (busy_a[i]),
            .ex_ready_o   (ex_ready_a[i]),
            .res_ready_o  (res_ready_a[i])
        );
    end

    // ------------------------------
    // Status and output muxes
    // ------------------------------
    assign arr_if.tail_free = ~valid_a[arr_if.tail_idx];
    assign arr_if.ex_ready  = ex_ready_a[arr_if.ex_idx];
    assign arr_if.res_ready = res_ready_a[arr_if.head_idx];
    assign arr_if.wr_busy   = busy_a[arr_if.wr_res_idx];

    assign ex_entry   = entries_a[arr_if.ex_idx];    // Next branch to dispatch
    assign head_entry = entries_a[arr_if.head_idx];  // Oldest branch in the station

    assign bu_rs1_o         = ex_entry.rs1_value;
    assign bu_rs2_o         = ex_entry.rs2_value;
    assign bu_imm_o         = ex_entry.imm_value;
    assign bu_pred_pc_o     = ex_entry.pred_pc;
    assign bu_pred_target_o = ex_entry.pred_target;
    assign bu_pred_taken_o  = ex_entry.pred_taken;
    assign bu_branch_type_o = ex_entry.branch_type;

    assign cdb_rob_idx_o = head_entry.res_idx;
    // The ROB reads the mispredict flag from the value field
    assign cdb_value_o   = {{(XLEN-1){1'b0}}, head_entry.mispredicted};

endmodule

/* bu_rs_ctrl.sv */
// Pointer bookkeeping and handshake decisions of the branch reservation station
module bu_rs_ctrl #(
    parameter int unsigned RS_DEPTH = bu_rs_cfg_pkg::RS_DEPTH_DEFAULT
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      arbiter_valid_i,
    input  logic      bu_ready_i,
    input  logic      bu_valid_i,
    input  logic      cdb_ready_i,
    output logic      arbiter_ready_o,
    output logic      bu_valid_o,
    output logic      cdb_valid_o,
    rs_ctrl_if.ctrl   ctrl_if
);

    localparam int unsigned IDX_W = $clog2(RS_DEPTH);

    logic [IDX_W-1:0] tail_q, ex_q, wr_res_q, head_q;

    // ------------------------------
    // Handshakes
    // ------------------------------
    assign arbiter_ready_o = ctrl_if.tail_free;  // Room at tail
    assign bu_valid_o      = ctrl_if.ex_ready;   // Oldest undispatched branch can go
    assign cdb_valid_o     = ctrl_if.res_ready;  // Oldest branch has its outcome

    // Strobes fire when both sides agree
    assign ctrl_if.push   = ctrl_if.tail_free & arbiter_valid_i;
    assign ctrl_if.ex     = ctrl_if.ex_ready  & bu_ready_i;
    assign ctrl_if.pop    = ctrl_if.res_ready & cdb_ready_i;
    // No ready toward the branch unit, stray results are dropped
    assign ctrl_if.wr_res = bu_valid_i & ctrl_if.wr_busy;

    assign ctrl_if.tail_idx   = tail_q;
    assign ctrl_if.ex_idx     = ex_q;
    assign ctrl_if.wr_res_idx = wr_res_q;
    assign ctrl_if.head_idx   = head_q;

    // ------------------------------
    // Pointers
    // ------------------------------
    // Power of two depth, so plain increments wrap
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tail_q   <= '0;
            ex_q     <= '0;
            wr_res_q <= '0;
            head_q   <= '0;
        end else if (flush_i) begin
            tail_q   <= '0;  // Station emptied, start over from slot 0
            ex_q     <= '0;
            wr_res_q <= '0;
            head_q   <= '0;
        end else begin
            if (ctrl_if.push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (ctrl_if.ex) begin
                ex_q <= ex_q + 1'b1;
            end
            if (ctrl_if.wr_res) begin
                wr_res_q <= wr_res_q + 1'b1;  // Results return in dispatch order
            end
            if (ctrl_if.pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

endmodule

/* bu_rs_top.sv */
// Top level of the branch reservation station, place this between the issue arbiter and the branch unit
module bu_rs_top #(
    parameter int unsigned RS_DEPTH = bu_rs_cfg_pkg::RS_DEPTH_DEFAULT  // Power of two
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,
    // Issue arbiter
    input  logic                                   arbiter_valid_i,
    output logic                                   arbiter_ready_o,
    input  bu_rs_types_pkg::branch_type_e          branch_type_i,
    input  logic                                   rs1_ready_i,
    input  logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  rs1_idx_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         rs1_value_i,
    input  logic                                   rs2_ready_i,
    input  logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  rs2_idx_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         rs2_value_i,
    input  logic [bu_rs_cfg_pkg::B_IMM-1:0]        imm_value_i,
    input  logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  dest_idx_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         pred_pc_i,
    input  logic [bu_rs_cfg_pkg::XLEN-1:0]         pred_target_i,
    input  logic                                   pred_taken_i,
    // Branch unit
    input  logic                                   bu_ready_i,
    output logic                                   bu_valid_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_rs1_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_rs2_o,
    output logic [bu_rs_cfg_pkg::B_IMM-1:0]        bu_imm_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_pred_pc_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         bu_pred_target_o,
    output logic                                   bu_pred_taken_o,
    output bu_rs_types_pkg::branch_type_e          bu_branch_type_o,
    input  logic                                   bu_valid_i,
    input  logic                                   mispredict_i,
    // CDB
    input  logic                                   cdb_valid_i,
    input  bu_rs_types_pkg::cdb_data_t             cdb_data_i,
    input  logic                                   cdb_ready_i,
    output logic                                   cdb_valid_o,
    output logic [bu_rs_cfg_pkg::ROB_IDX_LEN-1:0]  cdb_rob_idx_o,
    output logic [bu_rs_cfg_pkg::XLEN-1:0]         cdb_value_o
);

    rs_ctrl_if #(.RS_DEPTH(RS_DEPTH)) rs_if ();

    // ------------------------------
    // Controller
    // ------------------------------
    bu_rs_ctrl #(
        .RS_DEPTH (RS_DEPTH)
    ) u_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .arbiter_valid_i (arbiter_valid_i),
        .bu_ready_i      (bu_ready_i),
        .bu_valid_i      (bu_valid_i),
        .cdb_ready_i     (cdb_ready_i),
        .arbiter_ready_o (arbiter_ready_o),
        .bu_valid_o      (bu_valid_o),
        .cdb_valid_o     (cdb_valid_o),
        .ctrl_if         (rs_if.ctrl)
    );

    // ------------------------------
    // Entry array
    // ------------------------------
    bu_rs_slot_array #(
        .RS_DEPTH (RS_DEPTH)
    ) u_array (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .arr_if           (rs_if.array),
        .branch_type_i    (branch_type_i),
        .rs1_ready_i      (rs1_ready_i),
        .rs1_idx_i        (rs1_idx_i),
        .rs1_value_i      (rs1_value_i),
        .rs2_ready_i      (rs2_ready_i),
        .rs2_idx_i        (rs2_idx_i),
        .rs2_value_i      (rs2_value_i),
        .imm_value_i      (imm_value_i),
        .dest_idx_i       (dest_idx_i),
        .pred_pc_i        (pred_pc_i),
        .pred_target_i    (pred_target_i),
        .pred_taken_i     (pred_taken_i),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_data_i       (cdb_data_i),
        .mispredict_i     (mispredict_i),
        .bu_rs1_o         (bu_rs1_o),
        .bu_rs2_o         (bu_rs2_o),
        .bu_imm_o         (bu_imm_o),
        .bu_pred_pc_o     (bu_pred_pc_o),
        .bu_pred_target_o (bu_pred_target_o),
        .bu_pred_taken_o  (bu_pred_taken_o),
        .bu_branch_type_o (bu_branch_type_o),
        .cdb_rob_idx_o    (cdb_rob_idx_o),
        .cdb_value_o      (cdb_value_o)
    );

endmodule

/* tb_bu_rs.sv */
// Directed testbench for the branch reservation station with tb_bu_rs as the simulation top
module tb_bu_rs;

    timeunit 1ns;
    timeprecision 1ps;

    import bu_rs_cfg_pkg::*;
    import bu_rs_types_pkg::*;

    localparam int unsigned RS_DEPTH = RS_DEPTH_DEFAULT;
    localparam int unsigned TIMEOUT  = 64;  // Cycles allowed per wait loop

    logic                   clk_i, rst_n_i, flush_i;
    logic                   arbiter_valid_i, arbiter_ready_o;
    branch_type_e           branch_type_i, bu_branch_type_o;
    logic                   rs1_ready_i, rs2_ready_i, pred_taken_i;
    logic [ROB_IDX_LEN-1:0] rs1_idx_i, rs2_idx_i, dest_idx_i, cdb_rob_idx_o;
    logic [XLEN-1:0]        rs1_value_i, rs2_value_i, pred_pc_i, pred_target_i;
    logic [B_IMM-1:0]       imm_value_i, bu_imm_o;
    logic                   bu_ready_i, bu_valid_o, bu_valid_i, mispredict_i, bu_pred_taken_o;
    logic [XLEN-1:0]        bu_rs1_o, bu_rs2_o, bu_pred_pc_o, bu_pred_target_o, cdb_value_o;
    logic                   cdb_valid_i, cdb_ready_i, cdb_valid_o;
    cdb_data_t              cdb_data_i;

    rs_entry_t   pend_q[$];    // Pushed but not dispatched yet
    rs_entry_t   flight_q[$];  // Inside the branch unit model
    rs_entry_t   done_q[$];    // Outcome known, waiting for the CDB
    logic [15:0] lfsr_q;

    bu_rs_top #(.RS_DEPTH(RS_DEPTH)) dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    // ------------------------------
    // Random bits and failure exits
    // ------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16 14 13 11
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);  // One step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic fail_now(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic give_up(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            fail_now($sformatf("%s expected %b got %b", what, exp, act));
        end
    endtask

    task automatic check_dispatch(input rs_entry_t exp);
        if (bu_branch_type_o !== exp.branch_type || bu_rs1_o !== exp.rs1_value ||
            bu_rs2_o !== exp.rs2_value || bu_imm_o !== exp.imm_value ||
            bu_pred_pc_o !== exp.pred_pc || bu_pred_target_o !== exp.pred_target ||
            bu_pred_taken_o !== exp.pred_taken) begin
            fail_now($sformatf("dispatch expected %0d %h %h %h %h %h %b got %0d %h %h %h %h %h %b",
                exp.branch_type, exp.rs1_value, exp.rs2_value, exp.imm_value, exp.pred_pc,
                exp.pred_target, exp.pred_taken, bu_branch_type_o, bu_rs1_o, bu_rs2_o,
                bu_imm_o, bu_pred_pc_o, bu_pred_target_o, bu_pred_taken_o));
        end
    endtask

    task automatic check_cdb(input logic [ROB_IDX_LEN-1:0] exp_tag,
                             input logic [XLEN-1:0]        exp_val);
        if (cdb_rob_idx_o !== exp_tag || cdb_value_o !== exp_val) begin
            fail_now($sformatf("CDB expected tag %h value %h got tag %h value %h",
                exp_tag, exp_val, cdb_rob_idx_o, cdb_value_o));
        end
    endtask

    // ------------------------------
    // Drivers and branch unit model
    // ------------------------------
    task automatic make_branch(output rs_entry_t e);
        logic [31:0] r;
        r             = rand_bits(3) % 6;  // Six legal kinds
        e             = '0;
        e.branch_type = branch_type_e'(r[2:0]);
        e.rs1_idx     = ROB_IDX_LEN'(rand_bits(ROB_IDX_LEN));
        e.rs2_idx     = ROB_IDX_LEN'(rand_bits(ROB_IDX_LEN));
        e.rs1_value   = rand_bits(XLEN);
        e.rs2_value   = rand_bits(XLEN);
        e.imm_value   = B_IMM'(rand_bits(B_IMM));
        e.pred_pc     = rand_bits(XLEN);
        e.pred_target = rand_bits(XLEN);
        e.pred_taken  = rand_bits(1) != 0;
        e.res_idx     = ROB_IDX_LEN'(rand_bits(ROB_IDX_LEN));
    endtask

    task automatic push_branch(input rs_entry_t e, input logic r1, input logic r2);
        int unsigned n;
        n = 0;
        @(posedge clk_i);
        arbiter_valid_i <= 1'b1;
        branch_type_i   <= e.branch_type;
        rs1_ready_i     <= r1;
        rs1_idx_i       <= e.rs1_idx;
        rs1_value_i     <= e.rs1_value;
        rs2_ready_i     <= r2;
        rs2_idx_i       <= e.rs2_idx;
        rs2_value_i     <= e.rs2_value;
        imm_value_i     <= e.imm_value;
        dest_idx_i      <= e.res_idx;
        pred_pc_i       <= e.pred_pc;
        pred_target_i   <= e.pred_target;
        pred_taken_i    <= e.pred_taken;
        @(negedge clk_i);
        while (!arbiter_ready_o) begin
            n++;
            if (n > TIMEOUT) give_up("arbiter_ready_o");
            @(negedge clk_i);
        end
        @(posedge clk_i);  // Transfer on this edge
        arbiter_valid_i <= 1'b0;
        pend_q.push_back(e);
    endtask

    task automatic dispatch_one();
        int unsigned n;
        n = 0;
        @(posedge clk_i);
        bu_ready_i <= 1'b1;
        @(negedge clk_i);
        while (!bu_valid_o) begin
            n++;
            if (n > TIMEOUT) give_up("bu_valid_o");
            @(negedge clk_i);
        end
        check_dispatch(pend_q[0]);  // Oldest pushed branch goes first
        flight_q.push_back(pend_q.pop_front());
        @(posedge clk_i);
        bu_ready_i <= 1'b0;
    endtask

    // A single valid cycle delivers one result since results carry no ready
    task automatic return_result();
        logic [31:0] r;
        rs_entry_t   e;
        r = rand_bits(1);
        @(posedge clk_i);
        bu_valid_i   <= 1'b1;
        mispredict_i <= r[0];
        @(posedge clk_i);
        bu_valid_i   <= 1'b0;
        e              = flight_q.pop_front();
        e.mispredicted = r[0];
        done_q.push_back(e);
    endtask

    task automatic accept_cdb();
        int unsigned n;
        n = 0;
        @(posedge clk_i);
        cdb_ready_i <= 1'b1;
        @(negedge clk_i);
        while (!cdb_valid_o) begin
            n++;
            if (n > TIMEOUT) give_up("cdb_valid_o");
            @(negedge clk_i);
        end
        check_cdb(done_q[0].res_idx, XLEN'(done_q[0].mispredicted));  // Flag zero-extended
        void'(done_q.pop_front());
        @(posedge clk_i);
        cdb_ready_i <= 1'b0;
    endtask

    task automatic drain_all();
        while (pend_q.size() > 0) begin
            dispatch_one();
        end
        while (flight_q.size() > 0) begin
            return_result();
        end
        while (done_q.size() > 0) begin
            accept_cdb();
        end
    endtask

    task automatic push_ready(input int unsigned count);
        rs_entry_t e;
        for (int unsigned i = 0; i < count; i++) begin
            make_branch(e);
            push_branch(e, 1'b1, 1'b1);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_dispatch_order();
        push_ready(3);
        drain_all();
    endtask

    task automatic test_operand_capture();
        rs_entry_t   e;
        logic [31:0] bad_val, good_val;
        make_branch(e);
        push_branch(e, 1'b0, 1'b1);  // rs1 still in flight
        bad_val  = rand_bits(XLEN);
        good_val = rand_bits(XLEN);
        @(posedge clk_i);
        cdb_valid_i <= 1'b1;
        cdb_data_i  <= '{rob_idx: e.rs1_idx, value: bad_val, except_raised: 1'b1};
        @(posedge clk_i);
        cdb_valid_i <= 1'b0;
        repeat (2) begin
            @(negedge clk_i);
            check_flag(bu_valid_o, 1'b0, "bu_valid_o after faulted CDB tag");
        end
        @(posedge clk_i);
        cdb_valid_i <= 1'b1;
        cdb_data_i  <= '{rob_idx: e.rs1_idx, value: good_val, except_raised: 1'b0};
        @(posedge clk_i);
        cdb_valid_i <= 1'b0;
        @(negedge clk_i);
        check_flag(bu_valid_o, 1'b1, "bu_valid_o after CDB capture");
        e.rs1_value = good_val;  // Operand now comes from the CDB
        pend_q[0]   = e;
        drain_all();
    endtask

    task automatic test_result_order();
        push_ready(RS_DEPTH);
        dispatch_one();
        dispatch_one();
        return_result();  // One outcome back while others still wait
        drain_all();
    endtask

    task automatic test_backpressure();
        push_ready(RS_DEPTH);
        @(negedge clk_i);
        check_flag(arbiter_ready_o, 1'b0, "arbiter_ready_o with every entry valid");
        repeat (3) begin
            @(negedge clk_i);
            check_flag(bu_valid_o, 1'b1, "bu_valid_o while bu_ready_i is low");
            check_dispatch(pend_q[0]);
        end
        dispatch_one();
        return_result();
        repeat (4) begin
            @(negedge clk_i);
            check_flag(cdb_valid_o, 1'b1, "cdb_valid_o while cdb_ready_i is low");
            check_cdb(done_q[0].res_idx, XLEN'(done_q[0].mispredicted));
        end
        drain_all();
    endtask

    task automatic test_flush();
        push_ready(3);
        dispatch_one();
        dispatch_one();
        return_result();
        @(negedge clk_i);
        check_flag(cdb_valid_o, 1'b1, "cdb_valid_o before flush");
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
        check_flag(bu_valid_o, 1'b0, "bu_valid_o after flush");
        check_flag(cdb_valid_o, 1'b0, "cdb_valid_o after flush");
        check_flag(arbiter_ready_o, 1'b1, "arbiter_ready_o after flush");
        pend_q.delete();
        flight_q.delete();
        done_q.delete();
        push_ready(1);  // Station starts over from slot 0
        drain_all();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        lfsr_q          = 16'd90;
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        arbiter_valid_i = 1'b0;
        branch_type_i   = BEQ;
        rs1_ready_i     = 1'b0;
        rs1_idx_i       = '0;
        rs1_value_i     = '0;
        rs2_ready_i     = 1'b0;
        rs2_idx_i       = '0;
        rs2_value_i     = '0;
        imm_value_i     = '0;
        dest_idx_i      = '0;
        pred_pc_i       = '0;
        pred_target_i   = '0;
        pred_taken_i    = 1'b0;
        bu_ready_i      = 1'b0;
        bu_valid_i      = 1'b0;
        mispredict_i    = 1'b0;
        cdb_valid_i     = 1'b0;
        cdb_data_i      = '0;
        cdb_ready_i     = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flag(arbiter_ready_o, 1'b1, "arbiter_ready_o after reset");
        check_flag(bu_valid_o, 1'b0, "bu_valid_o after reset");
        check_flag(cdb_valid_o, 1'b0, "cdb_valid_o after reset");
        test_dispatch_order();
        test_operand_capture();
        test_result_order();
        test_backpressure();
        test_flush();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* src.f */
bu_rs_cfg_pkg.sv
bu_rs_types_pkg.sv
rs_ctrl_if.sv
bu_rs_entry.sv
bu_rs_slot_array.sv
bu_rs_ctrl.sv
bu_rs_top.sv
tb_bu_rs.sv

/* Bender.yml */
package:
  name: bu_rs

sources:
  - bu_rs_cfg_pkg.sv
  - bu_rs_types_pkg.sv
  - rs_ctrl_if.sv
  - bu_rs_entry.sv
  - bu_rs_slot_array.sv
  - bu_rs_ctrl.sv
  - bu_rs_top.sv
  - target: test
    files:
      - tb_bu_rs.sv
